//--- src/wbxbc_pkg.sv
// shared definitions for the wishbone bus splitter
//   bus and tag width constants
//   request payload struct, initiator to target
//   response payload struct, target to initiator

package wbxbc_pkg;

   //----------------------------------------------------------------------
   // bus widths
   //----------------------------------------------------------------------
   localparam int ADR_WIDTH  = 16;                 // address bus
   localparam int DAT_WIDTH  = 16;                 // read and write data bus
   localparam int SEL_WIDTH  = 2;                  // byte selects
   localparam int TGA_WIDTH  = 1;                  // address tag
   localparam int TGC_WIDTH  = 1;                  // cycle tag
   localparam int TGRD_WIDTH = 1;                  // read data tag
   localparam int TGWD_WIDTH = 1;                  // write data tag

   //----------------------------------------------------------------------
   // request payload
   //----------------------------------------------------------------------
   // everything but cyc and stb, which carry the handshake
   typedef struct packed {
      logic                  we;                   // write enable
      logic                  lock;                 // uninterruptable cycle
      logic [SEL_WIDTH-1:0]  sel;                  // byte selects
      logic [ADR_WIDTH-1:0]  adr;                  // address
      logic [DAT_WIDTH-1:0]  dat;                  // write data
      logic [TGA_WIDTH-1:0]  tga;                  // address tag
      logic [TGC_WIDTH-1:0]  tgc;                  // cycle tag
      logic [TGWD_WIDTH-1:0] tgd;                  // write data tag
   } wb_req_t;

   //----------------------------------------------------------------------
   // response payload
   //----------------------------------------------------------------------
   // ack, err, rty and stall travel as separate levels
   typedef struct packed {
      logic [DAT_WIDTH-1:0]  dat;                  // read data
      logic [TGRD_WIDTH-1:0] tgd;                  // read data tag
   } wb_rsp_t;

endpackage

//--- src/splitter_select.sv
// target select for the bus splitter
//   lowest-set-bit decode of the one-hot target tag
//   choice held for the duration of a bus cycle

`timescale 1ns/1ps

module splitter_select #(
   parameter int TGT_CNT = 4                       // number of targets
) (
   input  logic               clk_i,               // module clock
   input  logic               rst_n_i,             // async reset, active low
   input  logic               cyc_i,               // initiator bus cycle
   input  logic               stb_i,               // initiator strobe
   input  logic [TGT_CNT-1:0] tgtsel_i,            // target select tag
   output logic [TGT_CNT-1:0] sel_vec_o            // one-hot routing vector
);

   logic [TGT_CNT-1:0] tag_dec;                    // decoded live tag
   logic [TGT_CNT-1:0] sel_q;                      // held choice, zero when empty
   logic               held;                       // a choice is held

   //----------------------------------------------------------------------
   // priority decode
   //----------------------------------------------------------------------
   // x & -x isolates the lowest set bit, so a multi-hot tag
   // collapses to one target and an all-zero tag stays zero
   assign tag_dec = tgtsel_i & (~tgtsel_i + TGT_CNT'(1));

   assign held = |sel_q;                           // empty means no capture yet

   //----------------------------------------------------------------------
   // cycle hold
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         sel_q <= '0;                              // nothing held after reset
      end
      else if (!cyc_i)
      begin
         sel_q <= '0;                              // cycle over, release
      end
      else if (stb_i && !held)
      begin
         sel_q <= tag_dec;                         // first strobe of the cycle
      end
   end

   // held choice wins while the cycle lasts, live tag otherwise
   assign sel_vec_o = (cyc_i && held) ? sel_q : tag_dec;

endmodule

//--- src/splitter_target_port.sv
// one target port of the bus splitter
//   gates cyc and stb onto the target by its select bit
//   qualifies the target's response levels for the merge

`timescale 1ns/1ps

module splitter_target_port (
   // initiator side
   input  logic               cyc_i,               // initiator bus cycle
   input  logic               stb_i,               // initiator strobe
   input  logic               sel_i,               // this target is selected
   input  wbxbc_pkg::wb_req_t req_i,               // request payload

   // target side
   output logic               tgt_cyc_o,           // target bus cycle
   output logic               tgt_stb_o,           // target strobe
   output wbxbc_pkg::wb_req_t tgt_req_o,           // target request payload
   input  logic               tgt_ack_i,           // target acknowledge
   input  logic               tgt_err_i,           // target error
   input  logic               tgt_rty_i,           // target retry
   input  logic               tgt_stall_i,         // target back-pressure
   input  wbxbc_pkg::wb_rsp_t tgt_rsp_i,           // target read payload

   // towards the merge
   output logic               ack_o,               // qualified ack
   output logic               err_o,               // qualified err
   output logic               rty_o,               // qualified rty
   output logic               stall_o,             // qualified stall
   output wbxbc_pkg::wb_rsp_t rsp_o                // read payload, unqualified
);

   //----------------------------------------------------------------------
   // request path
   //----------------------------------------------------------------------
   assign tgt_cyc_o = cyc_i & sel_i;               // cycle only on selected target
   assign tgt_stb_o = stb_i & sel_i;               // strobes follow the cycle
   assign tgt_req_o = req_i;                       // payload shared by all targets

   //----------------------------------------------------------------------
   // response path
   //----------------------------------------------------------------------
   // an unselected target can still toggle its levels,
   // masking here lets the merge simply OR the ports
   assign ack_o   = tgt_ack_i   & sel_i;
   assign err_o   = tgt_err_i   & sel_i;
   assign rty_o   = tgt_rty_i   & sel_i;
   assign stall_o = tgt_stall_i & sel_i;           // foreign stall ignored

   assign rsp_o   = tgt_rsp_i;                     // merge muxes by sel_vec

endmodule

//--- src/splitter_response_merge.sv
// response merge of the bus splitter
//   ORs the qualified ack, err, rty and stall of all ports
//   read payload mux by the routing vector
//   err answer for a strobe with no target selected

`timescale 1ns/1ps

module splitter_response_merge #(
   parameter int TGT_CNT = 4                                // number of targets
) (
   input  logic                              cyc_i,         // initiator bus cycle
   input  logic                              stb_i,         // initiator strobe
   input  logic               [TGT_CNT-1:0]  sel_vec_i,     // one-hot routing vector
   input  logic               [TGT_CNT-1:0]  ack_i,         // qualified acks
   input  logic               [TGT_CNT-1:0]  err_i,         // qualified errs
   input  logic               [TGT_CNT-1:0]  rty_i,         // qualified retries
   input  logic               [TGT_CNT-1:0]  stall_i,       // qualified stalls
   input  wbxbc_pkg::wb_rsp_t [TGT_CNT-1:0]  rsp_i,         // raw read payloads
   output logic                              itr_ack_o,     // initiator ack
   output logic                              itr_err_o,     // initiator err
   output logic                              itr_rty_o,     // initiator retry
   output logic                              itr_stall_o,   // initiator stall
   output wbxbc_pkg::wb_rsp_t                itr_rsp_o      // initiator read payload
);

   import wbxbc_pkg::*;

   wb_rsp_t rsp_mux;                                        // payload of chosen target
   logic    unrouted;                                       // strobe without a target

   //----------------------------------------------------------------------
   // handshake levels
   //----------------------------------------------------------------------
   assign unrouted    = cyc_i & stb_i & ~|sel_vec_i;        // nobody would answer

   assign itr_ack_o   = |ack_i;
   assign itr_err_o   = |err_i | unrouted;                  // same-cycle err
   assign itr_rty_o   = |rty_i;
   assign itr_stall_o = |stall_i;                           // zero when unrouted

   //----------------------------------------------------------------------
   // read payload mux
   //----------------------------------------------------------------------
   always_comb
   begin
      rsp_mux = '0;                                         // idle bus reads zero
      for (int k = 0; k < TGT_CNT; k++)
      begin
         if (sel_vec_i[k])
         begin
            rsp_mux = rsp_i[k];                             // sel_vec is one-hot
         end
      end
   end

   assign itr_rsp_o = rsp_mux;

endmodule

//--- src/wbxbc_splitter.sv
// wishbone pipelined bus splitter, top level
//   one initiator port fanned out to TGT_CNT target ports
//   select, per-target ports and response merge

`timescale 1ns/1ps

module wbxbc_splitter #(
   parameter int TGT_CNT = 4                                // number of targets
) (
   input  logic                              clk_i,         // module clock
   input  logic                              rst_n_i,       // async reset, active low

   // initiator interface
   input  logic                              itr_cyc_i,     // bus cycle
   input  logic                              itr_stb_i,     // strobe
   input  wbxbc_pkg::wb_req_t                itr_req_i,     // request payload
   input  logic               [TGT_CNT-1:0]  itr_tgtsel_i,  // one-hot target tag
   output logic                              itr_ack_o,     // acknowledge
   output logic                              itr_err_o,     // error
   output logic                              itr_rty_o,     // retry
   output logic                              itr_stall_o,   // back-pressure
   output wbxbc_pkg::wb_rsp_t                itr_rsp_o,     // read payload

   // target interfaces
   output logic               [TGT_CNT-1:0]  tgt_cyc_o,     // bus cycles
   output logic               [TGT_CNT-1:0]  tgt_stb_o,     // strobes
   output wbxbc_pkg::wb_req_t [TGT_CNT-1:0]  tgt_req_o,     // request payloads
   input  logic               [TGT_CNT-1:0]  tgt_ack_i,     // acknowledges
   input  logic               [TGT_CNT-1:0]  tgt_err_i,     // errors
   input  logic               [TGT_CNT-1:0]  tgt_rty_i,     // retries
   input  logic               [TGT_CNT-1:0]  tgt_stall_i,   // back-pressure
   input  wbxbc_pkg::wb_rsp_t [TGT_CNT-1:0]  tgt_rsp_i      // read payloads
);

   import wbxbc_pkg::*;

   logic    [TGT_CNT-1:0] sel_vec;                          // routing vector
   logic    [TGT_CNT-1:0] port_ack;                         // qualified per port
   logic    [TGT_CNT-1:0] port_err;
   logic    [TGT_CNT-1:0] port_rty;
   logic    [TGT_CNT-1:0] port_stall;
   wb_rsp_t [TGT_CNT-1:0] port_rsp;                         // raw read payloads

   //----------------------------------------------------------------------
   // target select
   //----------------------------------------------------------------------
   splitter_select #(
      .TGT_CNT   (TGT_CNT)
   ) u_select (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .cyc_i     (itr_cyc_i),
      .stb_i     (itr_stb_i),
      .tgtsel_i  (itr_tgtsel_i),
      .sel_vec_o (sel_vec)
   );

   //----------------------------------------------------------------------
   // target ports
   //----------------------------------------------------------------------
   for (genvar k = 0; k < TGT_CNT; k++)
   begin : g_tgt
      splitter_target_port u_port (
         .cyc_i       (itr_cyc_i),
         .stb_i       (itr_stb_i),
         .sel_i       (sel_vec[k]),                         // own routing bit
         .req_i       (itr_req_i),
         .tgt_cyc_o   (tgt_cyc_o[k]),
         .tgt_stb_o   (tgt_stb_o[k]),
         .tgt_req_o   (tgt_req_o[k]),
         .tgt_ack_i   (tgt_ack_i[k]),
         .tgt_err_i   (tgt_err_i[k]),
         .tgt_rty_i   (tgt_rty_i[k]),
         .tgt_stall_i (tgt_stall_i[k]),
         .tgt_rsp_i   (tgt_rsp_i[k]),
         .ack_o       (port_ack[k]),
         .err_o       (port_err[k]),
         .rty_o       (port_rty[k]),
         .stall_o     (port_stall[k]),
         .rsp_o       (port_rsp[k])
      );
   end

   //----------------------------------------------------------------------
   // response merge
   //----------------------------------------------------------------------
   splitter_response_merge #(
      .TGT_CNT     (TGT_CNT)
   ) u_merge (
      .cyc_i       (itr_cyc_i),
      .stb_i       (itr_stb_i),
      .sel_vec_i   (sel_vec),
      .ack_i       (port_ack),
      .err_i       (port_err),
      .rty_i       (port_rty),
      .stall_i     (port_stall),
      .rsp_i       (port_rsp),
      .itr_ack_o   (itr_ack_o),
      .itr_err_o   (itr_err_o),
      .itr_rty_o   (itr_rty_o),
      .itr_stall_o (itr_stall_o),
      .itr_rsp_o   (itr_rsp_o)
   );

endmodule

//--- tb/wbxbc_splitter_props.sv
// concurrent assertions for the bus splitter
//   one target cycle at a time, strobe only inside a cycle
//   err answer for a strobe without a target

`timescale 1ns/1ps

module wbxbc_splitter_props #(
   parameter int TGT_CNT = 4                       // number of targets
) (
   input logic               clk_i,
   input logic               rst_n_i,
   input logic               itr_cyc_i,
   input logic               itr_stb_i,
   input logic               itr_err_o,
   input logic [TGT_CNT-1:0] tgt_cyc_o,
   input logic [TGT_CNT-1:0] tgt_stb_o
);

   int fail_cnt = 0;                               // assertion failure count

   a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(tgt_cyc_o))
   else
   begin
      fail_cnt++;
      $error("more than one target cycle active");
   end

   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (tgt_stb_o & ~tgt_cyc_o) == '0)
   else
   begin
      fail_cnt++;
      $error("target strobe outside its bus cycle");
   end

   // no target cycle raised means the strobe went nowhere
   a_unrouted_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (itr_cyc_i && itr_stb_i && tgt_cyc_o == '0) |-> itr_err_o)
   else
   begin
      fail_cnt++;
      $error("strobe without a target got no err");
   end

endmodule

bind wbxbc_splitter wbxbc_splitter_props #(
   .TGT_CNT   (TGT_CNT)
) u_props (
   .clk_i     (clk_i),
   .rst_n_i   (rst_n_i),
   .itr_cyc_i (itr_cyc_i),
   .itr_stb_i (itr_stb_i),
   .itr_err_o (itr_err_o),
   .tgt_cyc_o (tgt_cyc_o),
   .tgt_stb_o (tgt_stb_o)
);

//--- tb/tb_wbxbc_splitter.sv
// directed testbench for the wishbone bus splitter
//   clock, reset, target models and lfsr payloads
//   compare tasks and one task per behavior
//   watchdog on the total run time

`timescale 1ns/1ps

module tb_wbxbc_splitter;

   import wbxbc_pkg::*;

   localparam int TGT_CNT    = 4;
   localparam int CLK_PERIOD = 4;                  // ns
   localparam int NUM_TESTS  = 6;
   localparam int WDOG_NS    = NUM_TESTS * 200 * CLK_PERIOD;

   logic                      clk;
   logic                      rst_n;
   logic                      itr_cyc;
   logic                      itr_stb;
   wb_req_t                   itr_req;
   logic    [TGT_CNT-1:0]     itr_tgtsel;
   logic                      itr_ack_o;
   logic                      itr_err_o;
   logic                      itr_rty_o;
   logic                      itr_stall_o;
   wb_rsp_t                   itr_rsp_o;
   logic    [TGT_CNT-1:0]     tgt_cyc_o;
   logic    [TGT_CNT-1:0]     tgt_stb_o;
   wb_req_t [TGT_CNT-1:0]     tgt_req_o;
   logic    [TGT_CNT-1:0]     tgt_ack;           // target models, set by the tasks
   logic    [TGT_CNT-1:0]     tgt_err;
   logic    [TGT_CNT-1:0]     tgt_rty;
   logic    [TGT_CNT-1:0]     tgt_stall;
   wb_rsp_t [TGT_CNT-1:0]     tgt_rsp;

   logic [31:0] lfsr_state = 32'd77645;
   int          chk_cnt    = 0;
   int          err_cnt    = 0;

   wbxbc_splitter #(
      .TGT_CNT      (TGT_CNT)
   ) uut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .itr_cyc_i    (itr_cyc),
      .itr_stb_i    (itr_stb),
      .itr_req_i    (itr_req),
      .itr_tgtsel_i (itr_tgtsel),
      .itr_ack_o    (itr_ack_o),
      .itr_err_o    (itr_err_o),
      .itr_rty_o    (itr_rty_o),
      .itr_stall_o  (itr_stall_o),
      .itr_rsp_o    (itr_rsp_o),
      .tgt_cyc_o    (tgt_cyc_o),
      .tgt_stb_o    (tgt_stb_o),
      .tgt_req_o    (tgt_req_o),
      .tgt_ack_i    (tgt_ack),
      .tgt_err_i    (tgt_err),
      .tgt_rty_i    (tgt_rty),
      .tgt_stall_i  (tgt_stall),
      .tgt_rsp_i    (tgt_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   //----------------------------------------------------------------------
   // stimulus helpers
   //----------------------------------------------------------------------
   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val        = {val[30:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hA300_0000 : 32'h0);
      end
      return val;
   endfunction

   function automatic wb_req_t rand_req(input logic we);
      wb_req_t r;
      r.we   = we;
      r.lock = 1'(rand_bits(1));
      r.sel  = SEL_WIDTH'(rand_bits(SEL_WIDTH));
      r.adr  = ADR_WIDTH'(rand_bits(ADR_WIDTH));
      r.dat  = DAT_WIDTH'(rand_bits(DAT_WIDTH));
      r.tga  = TGA_WIDTH'(rand_bits(TGA_WIDTH));
      r.tgc  = TGC_WIDTH'(rand_bits(TGC_WIDTH));
      r.tgd  = TGWD_WIDTH'(rand_bits(TGWD_WIDTH));
      return r;
   endfunction

   function automatic wb_rsp_t rand_rsp();
      wb_rsp_t r;
      r.dat = DAT_WIDTH'(rand_bits(DAT_WIDTH));
      r.tgd = TGRD_WIDTH'(rand_bits(TGRD_WIDTH));
      return r;
   endfunction

   // expected route, lowest set bit of the tag wins
   function automatic logic [TGT_CNT-1:0] lowest_bit(input logic [TGT_CNT-1:0] tag);
      logic [TGT_CNT-1:0] hot;
      hot = '0;
      for (int k = TGT_CNT-1; k >= 0; k--)
      begin
         if (tag[k])
         begin
            hot = TGT_CNT'(1) << k;
         end
      end
      return hot;
   endfunction

   task automatic targets_quiet();
      tgt_ack   = '0;
      tgt_err   = '0;
      tgt_rty   = '0;
      tgt_stall = '0;
      tgt_rsp   = '0;
   endtask

   // strobe driven at the falling edge, outputs sampled 1 ns later
   task automatic open_strobe(input logic [TGT_CNT-1:0] tag, input wb_req_t req);
      @(negedge clk);
      itr_cyc    = 1'b1;
      itr_stb    = 1'b1;
      itr_tgtsel = tag;
      itr_req    = req;
      #1;
   endtask

   //----------------------------------------------------------------------
   // compare tasks
   //----------------------------------------------------------------------
   task automatic check_bit(input logic got, input logic exp, input string what);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_req(input wb_req_t got, input wb_req_t exp, input string what);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input string what);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_targets(input logic [TGT_CNT-1:0] exp_cyc,
                                input logic [TGT_CNT-1:0] exp_stb, input string what);
      for (int k = 0; k < TGT_CNT; k++)
      begin
         check_bit(tgt_cyc_o[k], exp_cyc[k], $sformatf("%s tgt_cyc_o[%0d]", what, k));
         check_bit(tgt_stb_o[k], exp_stb[k], $sformatf("%s tgt_stb_o[%0d]", what, k));
      end
   endtask

   task automatic end_cycle();
      @(negedge clk);
      itr_cyc = 1'b0;
      itr_stb = 1'b0;
      targets_quiet();
      #1;
      check_targets('0, '0, "idle");
   endtask

   task automatic wait_unstalled(input int limit, output int waited);
      waited = 0;
      while (itr_stall_o && waited <= limit)
      begin
         @(negedge clk);
         #1;
         waited++;
      end
      if (itr_stall_o)
      begin
         err_cnt++;
         $display("stall to the initiator never dropped within %0d cycles", limit);
      end
   endtask

   //----------------------------------------------------------------------
   // directed tests
   //----------------------------------------------------------------------
   task automatic test_reset_idle();
      @(negedge clk);
      itr_tgtsel = '1;                             // live tag, but no cycle
      #1;
      check_targets('0, '0, "reset");
      check_bit(itr_ack_o, 1'b0, "reset itr_ack_o");
      check_bit(itr_err_o, 1'b0, "reset itr_err_o");
      check_bit(itr_rty_o, 1'b0, "reset itr_rty_o");
   endtask

   task automatic test_routing();
      wb_req_t            req;
      logic [TGT_CNT-1:0] tag;
      for (int k = 0; k < TGT_CNT; k++)
      begin
         tag = TGT_CNT'(1) << k;
         req = rand_req(1'b1);
         open_strobe(tag, req);
         check_targets(tag, tag, "routing");
         check_req(tgt_req_o[k], req, "routing tgt_req_o");
         @(negedge clk);
         itr_stb    = 1'b0;
         tgt_ack[k] = 1'b1;                        // write acked one cycle later
         #1;
         check_bit(itr_ack_o, 1'b1, "routing itr_ack_o");
         check_targets(tag, '0, "routing after strobe");
         end_cycle();
      end
   endtask

   task automatic test_read_response();
      wb_rsp_t            rsp [TGT_CNT];
      logic [TGT_CNT-1:0] tag;
      for (int k = 0; k < TGT_CNT; k++)
      begin
         tag = TGT_CNT'(1) << k;
         open_strobe(tag, rand_req(1'b0));
         @(negedge clk);
         itr_stb = 1'b0;
         for (int j = 0; j < TGT_CNT; j++)
         begin
            rsp[j]     = rand_rsp();
            tgt_rsp[j] = rsp[j];
            tgt_ack[j] = (j != k);                 // foreign responses only
            tgt_err[j] = (j != k);
            tgt_rty[j] = (j != k);
         end
         #1;
         check_bit(itr_ack_o, 1'b0, "foreign itr_ack_o");
         check_bit(itr_err_o, 1'b0, "foreign itr_err_o");
         check_bit(itr_rty_o, 1'b0, "foreign itr_rty_o");
         @(negedge clk);
         tgt_ack = '1;                             // everyone acks at once
         tgt_err = '0;
         tgt_rty = '0;
         #1;
         check_bit(itr_ack_o, 1'b1, "read itr_ack_o");
         check_rsp(itr_rsp_o, rsp[k], "read itr_rsp_o");
         end_cycle();
      end
   endtask

   task automatic test_cycle_hold();
      wb_req_t req;
      open_strobe(TGT_CNT'(1), rand_req(1'b1));
      check_targets(TGT_CNT'(1), TGT_CNT'(1), "hold first strobe");
      for (int i = 0; i < 2; i++)
      begin
         req = rand_req(1'b1);
         @(negedge clk);
         itr_tgtsel = TGT_CNT'(4);                 // tag moves mid-cycle
         itr_req    = req;
         #1;
         check_targets(TGT_CNT'(1), TGT_CNT'(1), "hold later strobe");
         check_req(tgt_req_o[0], req, "hold tgt_req_o");
      end
      end_cycle();
      open_strobe(TGT_CNT'(4), rand_req(1'b1));
      check_targets(TGT_CNT'(4), TGT_CNT'(4), "hold new cycle");
      end_cycle();
   endtask

   task automatic test_back_pressure();
      int stall_cycles;
      int waited;
      stall_cycles = 1 + int'(rand_bits(2));
      @(negedge clk);
      tgt_stall    = TGT_CNT'(2);                  // only target 1 stalls
      open_strobe(TGT_CNT'(2), rand_req(1'b1));
      check_bit(itr_stall_o, 1'b1, "selected stall");
      fork
         begin
            repeat (stall_cycles) @(negedge clk);
            tgt_stall = ~TGT_CNT'(2);              // foreign targets stall now
         end
         wait_unstalled(10, waited);
      join
      chk_cnt++;
      if (waited != stall_cycles)
      begin
         err_cnt++;
         $display("ERR %0t: stall lasted %0d cycles, expected %0d", $time, waited,
                  stall_cycles);
      end
      @(negedge clk);
      itr_stb    = 1'b0;
      tgt_stall  = '0;
      tgt_ack[1] = 1'b1;
      #1;
      check_bit(itr_ack_o, 1'b1, "stall itr_ack_o");
      end_cycle();
   endtask

   task automatic test_tag_edges();
      logic [TGT_CNT-1:0] tag;
      logic [TGT_CNT-1:0] hot;
      for (int i = 0; i < 4; i++)
      begin
         tag = TGT_CNT'(rand_bits(TGT_CNT));
         if ($countones(tag) < 2)
         begin
            tag = tag | TGT_CNT'(10);              // force a multi-hot tag
         end
         hot = lowest_bit(tag);
         open_strobe(tag, rand_req(1'b1));
         check_targets(hot, hot, $sformatf("multi-hot tag %b", tag));
         check_bit(itr_err_o, 1'b0, "multi-hot itr_err_o");
         end_cycle();
      end
      open_strobe('0, rand_req(1'b0));
      check_bit(itr_err_o, 1'b1, "unrouted itr_err_o");
      check_targets('0, '0, "unrouted");
      @(negedge clk);
      itr_stb = 1'b0;
      #1;
      check_bit(itr_err_o, 1'b0, "unrouted err after strobe");
      end_cycle();
   endtask

   //----------------------------------------------------------------------
   // main sequence and watchdog
   //----------------------------------------------------------------------
   initial
   begin
      itr_cyc    = 1'b0;
      itr_stb    = 1'b0;
      itr_req    = '0;
      itr_tgtsel = '0;
      targets_quiet();
      rst_n      = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n      = 1'b1;
      test_reset_idle();
      test_routing();
      test_read_response();
      test_cycle_hold();
      test_back_pressure();
      test_tag_edges();
      $display("checks %0d, errors %0d, assertion failures %0d", chk_cnt, err_cnt,
               uut.u_props.fail_cnt);
      if (err_cnt == 0 && uut.u_props.fail_cnt == 0)
      begin
         $display("Test passed");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

   initial
   begin
      #(WDOG_NS);
      $display("timeout, the test sequence did not finish in %0d ns", WDOG_NS);
      $display("Test failed");
      $finish;
   end

endmodule

//--- compile.f
src/wbxbc_pkg.sv
src/splitter_select.sv
src/splitter_target_port.sv
src/splitter_response_merge.sv
src/wbxbc_splitter.sv
tb/wbxbc_splitter_props.sv
tb/tb_wbxbc_splitter.sv

//--- Makefile
# Verilator build and run of the bus splitter testbench

VERILATOR ?= verilator
TOP       ?= tb_wbxbc_splitter
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
